/* hw/frame_buffer.sv */
// Circular store for two frames of input beats
// The input side writes while a slot is free; the output side reads the head
// beat and pops it once it has been used
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module frame_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rms_norm_pkg::lane_beat_u in_data,
  input  logic                     buf_push,
  input  logic                     buf_pop,
  output rms_norm_pkg::lane_beat_u head_data,
  output logic                     buf_nonempty,
  output logic                     buf_free_frame
);

  localparam int DEPTH = 2 * `RMS_BEATS;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] FULL_FILL = DEPTH[AW:0];

  logic [`RMS_BEAT_W-1:0] mem [DEPTH];
  // One wrap bit above the address
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] fill;

  assign fill           = wr_ptr - rd_ptr;
  assign buf_nonempty   = (fill != '0);
  assign buf_free_frame = (fill != FULL_FILL);
  assign head_data.raw  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (buf_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (buf_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_push) begin
      mem[wr_ptr[AW-1:0]] <= in_data.raw;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) buf_push |-> buf_free_frame)
    else $error("push into a full frame buffer");
  assert property (@(posedge clk) disable iff (!rst_n) buf_pop |-> buf_nonempty)
    else $error("pop from an empty frame buffer");

endmodule

/* hw/inv_sqrt_unit.sv */
// Inverse square root of the mean square of a frame
// Stage 1 divides the sum by the value count and finds the leading one;
// stage 2 looks up the root by exponent parity and mantissa and scales it.
// isq_valid follows sum_valid by two cycles
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module inv_sqrt_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  rms_norm_pkg::acc_t sum_sq,
  input  logic               sum_valid,
  output rms_norm_pkg::isq_t isq,
  output logic               isq_valid
);

  localparam int ACC_W      = `RMS_ACC_W;
  localparam int POS_W      = $clog2(ACC_W);
  localparam int LUT_POW    = `RMS_LUT_POW;
  localparam int LUT_N      = 2 ** (LUT_POW + 1);
  // Extra fraction bits cover the largest up-shift of the smallest mean
  localparam int ENTRY_FRAC = `RMS_ISQ_FRAC + `RMS_ACC_FRAC / 2;

  // Upper half of the table holds the odd exponents, scaled by 2
  function automatic rms_norm_pkg::isq_t lut_entry(input int idx);
    real y;
    y = 1.0 + real'(idx % (2 ** LUT_POW)) / real'(2 ** LUT_POW);
    if (idx >= 2 ** LUT_POW) begin
      y = 2.0 * y;
    end
    return rms_norm_pkg::isq_t'($rtoi(real'(2 ** ENTRY_FRAC) / $sqrt(y)));
  endfunction

  rms_norm_pkg::isq_t lut [LUT_N];

  for (genvar g = 0; g < LUT_N; g++) begin : g_lut
    localparam rms_norm_pkg::isq_t ENTRY = lut_entry(g);
    assign lut[g] = ENTRY;
  end

  rms_norm_pkg::acc_t mean;
  logic [POS_W-1:0]   lead;
  rms_norm_pkg::acc_t m1;
  logic [POS_W-1:0]   pos1;
  logic               v1;
  rms_norm_pkg::acc_t norm;
  logic [LUT_POW-1:0] mant;
  logic [LUT_POW:0]   idx;
  rms_norm_pkg::isq_t root;

  // Mean and leading-one position
  always_comb begin
    mean = sum_sq >> `RMS_NUM_LOG2;
    lead = '0;
    for (int b = 0; b < ACC_W; b++) begin
      if (mean[b]) begin
        lead = POS_W'(b);
      end
    end
  end

  // Leading one moved to the top bit; bits below the mantissa drop out.
  // The even fraction width makes parity and half exponent come from pos1
  always_comb begin
    norm = m1 << (POS_W'(ACC_W - 1) - pos1);
    mant = norm[ACC_W-2 -: LUT_POW];
    idx  = {pos1[0], mant};
    root = (m1 == '0) ? '1 : lut[idx] >> pos1[POS_W-1:1];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1        <= 1'b0;
      isq_valid <= 1'b0;
    end else begin
      v1        <= sum_valid;
      isq_valid <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      m1   <= mean;
      pos1 <= lead;
    end
    if (v1) begin
      isq <= root;
    end
  end

endmodule

/* hw/norm_scale_lanes.sv */
// Per-lane scaling by the inverse root and the weight
// Stage 1 multiplies by the inverse root, stage 2 by the weight, then floors
// and saturates to the output format. Both stages advance together
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module norm_scale_lanes (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rms_norm_pkg::lane_beat_u head_data,
  input  rms_norm_pkg::lane_beat_u wt_data,
  input  rms_norm_pkg::isq_t       held_isq,
  input  logic                     lane_en,
  input  logic                     lane_last,
  input  logic                     out_ready,
  output logic                     stage_ready,
  output rms_norm_pkg::lane_beat_u out_data,
  output logic                     out_valid,
  output logic                     out_last
);

  localparam int NORM_W = `RMS_IN_W + `RMS_ISQ_W + 1;
  localparam int PROD_W = NORM_W + `RMS_WT_W;
  localparam int SHIFT  = `RMS_IN_FRAC + `RMS_ISQ_FRAC + `RMS_WT_FRAC - `RMS_OUT_FRAC;
  localparam logic signed [PROD_W-1:0] OUT_MAX = PROD_W'(2 ** (`RMS_OUT_W - 1) - 1);
  localparam logic signed [PROD_W-1:0] OUT_MIN = -OUT_MAX - 1;

  logic signed [NORM_W-1:0] norm_d  [`RMS_LANES];
  logic signed [NORM_W-1:0] s1_norm [`RMS_LANES];
  rms_norm_pkg::lane_beat_u s1_wt;
  logic                     s1_valid;
  logic                     s1_last;
  logic signed [PROD_W-1:0] prod    [`RMS_LANES];
  logic signed [PROD_W-1:0] scaled  [`RMS_LANES];
  rms_norm_pkg::lane_beat_u result;

  // Output register empty or draining
  assign stage_ready = !out_valid || out_ready;

  // Lane times unsigned root
  always_comb begin
    for (int i = 0; i < `RMS_LANES; i++) begin
      norm_d[i] = $signed(head_data.lane[i]) * $signed({1'b0, held_isq});
    end
  end

  // Weight product, floor by arithmetic shift, then clamp
  always_comb begin
    for (int i = 0; i < `RMS_LANES; i++) begin
      prod[i]   = s1_norm[i] * $signed(s1_wt.lane[i]);
      scaled[i] = prod[i] >>> SHIFT;
      if (scaled[i] > OUT_MAX) begin
        result.lane[i] = OUT_MAX[`RMS_OUT_W-1:0];
      end else if (scaled[i] < OUT_MIN) begin
        result.lane[i] = OUT_MIN[`RMS_OUT_W-1:0];
      end else begin
        result.lane[i] = scaled[i][`RMS_OUT_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_last   <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (stage_ready) begin
      s1_valid  <= lane_en;
      s1_last   <= lane_en && lane_last;
      out_valid <= s1_valid;
      out_last  <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_ready) begin
      if (lane_en) begin
        s1_norm <= norm_d;
        s1_wt   <= wt_data;
      end
      if (s1_valid) begin
        out_data <= result;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else $error("output beat changed while stalled");

endmodule

/* hw/rms_norm_ctrl.sv */
// Handshake control of the RMS normalization block
// Counts input and output beats, joins the buffer, weight and inverse-root
// streams, and holds one inverse root per frame with one queued behind it
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module rms_norm_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic               buf_free_frame,
  input  logic               buf_nonempty,
  output logic               buf_push,
  output logic               buf_pop,
  output logic               acc_en,
  output logic               acc_last,
  input  logic               isq_valid,
  input  rms_norm_pkg::isq_t isq,
  input  logic               wt_valid,
  output logic               wt_ready,
  output logic               lane_en,
  output logic               lane_last,
  output rms_norm_pkg::isq_t held_isq,
  input  logic               stage_ready
);

  localparam int CNT_W = $clog2(`RMS_BEATS);
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`RMS_BEATS - 1);

  logic [CNT_W-1:0]   in_cnt;
  logic [CNT_W-1:0]   out_cnt;
  logic               in_fire;
  logic               out_fire;
  logic               frame_done;
  logic               held_valid;
  logic               queue_valid;
  rms_norm_pkg::isq_t queue_isq;

  // Input side feeds buffer and accumulator together
  assign in_ready = buf_free_frame;
  assign in_fire  = in_valid && in_ready;
  assign buf_push = in_fire;
  assign acc_en   = in_fire;
  assign acc_last = in_fire && (in_cnt == LAST_BEAT);

  // Output join of buffered beat, weight beat and held root
  assign out_fire   = buf_nonempty && held_valid && wt_valid && stage_ready;
  assign buf_pop    = out_fire;
  assign wt_ready   = out_fire;
  assign lane_en    = out_fire;
  assign lane_last  = (out_cnt == LAST_BEAT);
  assign frame_done = out_fire && lane_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_cnt      <= '0;
      out_cnt     <= '0;
      held_valid  <= 1'b0;
      queue_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        in_cnt <= (in_cnt == LAST_BEAT) ? '0 : in_cnt + 1'b1;
      end
      if (out_fire) begin
        out_cnt <= lane_last ? '0 : out_cnt + 1'b1;
      end
      // Retire the finished frame's root, promote the queued one
      if (frame_done) begin
        held_valid  <= queue_valid || isq_valid;
        queue_valid <= queue_valid && isq_valid;
      end else if (isq_valid) begin
        if (held_valid) begin
          queue_valid <= 1'b1;
        end else begin
          held_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_done) begin
      held_isq <= queue_valid ? queue_isq : isq;
      if (isq_valid) begin
        queue_isq <= isq;
      end
    end else if (isq_valid) begin
      if (held_valid) begin
        queue_isq <= isq;
      end else begin
        held_isq <= isq;
      end
    end
  end

  // Buffer depth keeps a third root from arriving before a slot frees
  assert property (@(posedge clk) disable iff (!rst_n)
    isq_valid |-> !(held_valid && queue_valid))
    else $error("inverse root arrived with both slots full");

endmodule

/* hw/rms_norm_pkg.sv */
// Shared types of the RMS normalization block
// Referenced by scoped name from the RTL and the testbench
`include "rms_norm_defs.svh"

package rms_norm_pkg;

  // One stream beat, seen either as a flat word or as its lanes
  // Lanes are two's complement and are read through $signed
  typedef union packed {
    logic [`RMS_BEAT_W-1:0]                raw;
    logic [`RMS_LANES-1:0][`RMS_IN_W-1:0]  lane;
  } lane_beat_u;

  // Sum of squares over a frame, RMS_ACC_FRAC fraction bits
  typedef logic [`RMS_ACC_W-1:0] acc_t;

  // Inverse square root, RMS_ISQ_FRAC fraction bits
  typedef logic [`RMS_ISQ_W-1:0] isq_t;

endpackage

/* hw/rms_norm_top.sv */
// RMS normalization block for a streaming fixed-point datapath
// Takes frames of input beats and a matching weight stream, and emits each
// beat normalized by the frame's RMS and scaled by its weight
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module rms_norm_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`RMS_BEAT_W-1:0] in_data,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [`RMS_BEAT_W-1:0] wt_data,
  input  logic                   wt_valid,
  output logic                   wt_ready,
  output logic [`RMS_BEAT_W-1:0] out_data,
  output logic                   out_valid,
  output logic                   out_last,
  input  logic                   out_ready
);

  logic                     buf_free_frame;
  logic                     buf_nonempty;
  logic                     buf_push;
  logic                     buf_pop;
  rms_norm_pkg::lane_beat_u head_data;
  logic                     acc_en;
  logic                     acc_last;
  rms_norm_pkg::acc_t       sum_sq;
  logic                     sum_valid;
  rms_norm_pkg::isq_t       isq;
  logic                     isq_valid;
  rms_norm_pkg::isq_t       held_isq;
  logic                     lane_en;
  logic                     lane_last;
  logic                     stage_ready;

  rms_norm_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .buf_free_frame (buf_free_frame),
    .buf_nonempty   (buf_nonempty),
    .buf_push       (buf_push),
    .buf_pop        (buf_pop),
    .acc_en         (acc_en),
    .acc_last       (acc_last),
    .isq_valid      (isq_valid),
    .isq            (isq),
    .wt_valid       (wt_valid),
    .wt_ready       (wt_ready),
    .lane_en        (lane_en),
    .lane_last      (lane_last),
    .held_isq       (held_isq),
    .stage_ready    (stage_ready)
  );

  frame_buffer u_buf (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_data        (in_data),
    .buf_push       (buf_push),
    .buf_pop        (buf_pop),
    .head_data      (head_data),
    .buf_nonempty   (buf_nonempty),
    .buf_free_frame (buf_free_frame)
  );

  square_accumulator u_acc (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .acc_en    (acc_en),
    .acc_last  (acc_last),
    .sum_sq    (sum_sq),
    .sum_valid (sum_valid)
  );

  inv_sqrt_unit u_isq (
    .clk       (clk),
    .rst_n     (rst_n),
    .sum_sq    (sum_sq),
    .sum_valid (sum_valid),
    .isq       (isq),
    .isq_valid (isq_valid)
  );

  norm_scale_lanes u_scale (
    .clk         (clk),
    .rst_n       (rst_n),
    .head_data   (head_data),
    .wt_data     (wt_data),
    .held_isq    (held_isq),
    .lane_en     (lane_en),
    .lane_last   (lane_last),
    .out_ready   (out_ready),
    .stage_ready (stage_ready),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_last    (out_last)
  );

endmodule

/* hw/square_accumulator.sv */
// Sum of squares over one frame
// Each accepted beat adds the squares of its lanes; the last beat of a frame
// publishes the total one cycle later and restarts the sum from zero
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module square_accumulator (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rms_norm_pkg::lane_beat_u in_data,
  input  logic                     acc_en,
  input  logic                     acc_last,
  output rms_norm_pkg::acc_t       sum_sq,
  output logic                     sum_valid
);

  localparam int SQ_W = 2 * `RMS_IN_W;

  logic [SQ_W-1:0]    lane_sq [`RMS_LANES];
  rms_norm_pkg::acc_t beat_sum;
  rms_norm_pkg::acc_t running;

  // Squares are never negative, so zero extension is safe
  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < `RMS_LANES; i++) begin
      lane_sq[i] = $signed(in_data.lane[i]) * $signed(in_data.lane[i]);
      beat_sum   = beat_sum + rms_norm_pkg::acc_t'(lane_sq[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running   <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= acc_last;
      if (acc_en) begin
        // Next frame starts from zero
        running <= acc_last ? '0 : running + beat_sum;
      end
    end
  end

  // Frame total, including the last beat
  always_ff @(posedge clk) begin
    if (acc_last) begin
      sum_sq <= running + beat_sum;
    end
  end

endmodule

/* include/rms_norm_defs.svh */
// Build-time parameters of the RMS normalization block
// Included by the package and by every module that sizes logic from them
`ifndef RMS_NORM_DEFS_SVH
`define RMS_NORM_DEFS_SVH

// Frame shape
`define RMS_LANES     4
`define RMS_BEATS     8
// log2 of the value count per frame (lanes times beats)
`define RMS_NUM_LOG2  5

// Signed input, weight and output formats
`define RMS_IN_W      8
`define RMS_IN_FRAC   2
`define RMS_WT_W      8
`define RMS_WT_FRAC   2
`define RMS_OUT_W     8
`define RMS_OUT_FRAC  4
`define RMS_BEAT_W    (`RMS_LANES * `RMS_IN_W)

// Unsigned sum of squares and inverse root
`define RMS_ACC_W     24
`define RMS_ACC_FRAC  4
`define RMS_ISQ_W     16
`define RMS_ISQ_FRAC  12
`define RMS_LUT_POW   5

`endif

/* run.sh */
#!/bin/sh
# Build the RMS normalization testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module rms_norm_tb -f src.f -o rms_norm_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/rms_norm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "Simulation ended without a closing verdict"
  exit 1
fi
exit 0

/* src.f */
+incdir+include
hw/rms_norm_pkg.sv
hw/rms_norm_ctrl.sv
hw/square_accumulator.sv
hw/inv_sqrt_unit.sv
hw/frame_buffer.sv
hw/norm_scale_lanes.sv
hw/rms_norm_top.sv
tests/rms_norm_checks.sv
tests/rms_norm_tb.sv

/* tests/rms_norm_checks.sv */
// Concurrent checks on the top-level ports of the RMS normalization block
// Compares each output beat with the expected head given by the testbench,
// watches stalls and buffer occupancy, and counts every failure
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module rms_norm_checks (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic                   in_ready,
  input  logic                   wt_valid,
  input  logic                   wt_ready,
  input  logic [`RMS_BEAT_W-1:0] out_data,
  input  logic                   out_valid,
  input  logic                   out_last,
  input  logic                   out_ready,
  input  logic [`RMS_BEAT_W-1:0] exp_data,
  input  logic                   exp_last,
  input  logic                   exp_avail,
  input  logic [127:0]           test_name,
  output int                     data_errs,
  output int                     last_errs,
  output int                     stall_errs,
  output int                     fill_errs,
  output int                     misc_errs
);

  int                     in_acc;
  int                     wt_acc;
  logic [`RMS_BEAT_W-1:0] prev_data;

  initial begin
    data_errs  = 0;
    last_errs  = 0;
    stall_errs = 0;
    fill_errs  = 0;
    misc_errs  = 0;
  end

  // Accepted inputs minus beats taken out for scaling (one weight each)
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_acc <= 0;
      wt_acc <= 0;
    end else begin
      if (in_valid && in_ready) begin
        in_acc <= in_acc + 1;
      end
      if (wt_valid && wt_ready) begin
        wt_acc <= wt_acc + 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    prev_data <= out_data;
  end

  // Bit order is in_ready, wt_ready, out_valid, out_last
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rst_n) |-> in_ready && !wt_ready && !out_valid && !out_last)
    else begin
      misc_errs++;
      $display("ERR %0s reset handshake expected %b actual %b", test_name, 4'b1000,
               {$sampled(in_ready), $sampled(wt_ready), $sampled(out_valid),
                $sampled(out_last)});
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready |-> exp_avail)
    else begin
      misc_errs++;
      $display("Output beat %h arrived with none expected in test %0s",
               $sampled(out_data), test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready && exp_avail |-> out_data == exp_data)
    else begin
      data_errs++;
      $display("ERR %0s out_data expected %h actual %h", test_name,
               $sampled(exp_data), $sampled(out_data));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready && exp_avail |-> out_last == exp_last)
    else begin
      last_errs++;
      $display("ERR %0s out_last expected %0b actual %0b", test_name,
               $sampled(exp_last), $sampled(out_last));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else begin
      stall_errs++;
      $display("ERR %0s stalled out_valid expected 1 actual %0b", test_name,
               $sampled(out_valid));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_data == prev_data)
    else begin
      stall_errs++;
      $display("ERR %0s stalled out_data expected %h actual %h", test_name,
               $sampled(prev_data), $sampled(out_data));
    end

  // Never more than two frames waiting in the buffer
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_acc - wt_acc) <= 2 * `RMS_BEATS)
    else begin
      fill_errs++;
      $display("ERR %0s buffered beats expected at most %0d actual %0d", test_name,
               2 * `RMS_BEATS, $sampled(in_acc) - $sampled(wt_acc));
    end

endmodule

/* tests/rms_norm_tb.sv */
// Testbench for the RMS normalization block
// Builds frames and weights, predicts every output beat with a reference
// model, drives both streams with gaps and back-pressure, and lets the
// checker module compare the output stream against the expected queue
`timescale 1ns/1ps
`include "rms_norm_defs.svh"

module rms_norm_tb;

  localparam int TOTAL_FRAMES = 12;
  localparam int TIMEOUT_CYC  = 400 * TOTAL_FRAMES;
  // Lane times root has 14 fraction bits, times weight 16; output keeps 4
  localparam int OUT_SHIFT = `RMS_IN_FRAC + `RMS_ISQ_FRAC + `RMS_WT_FRAC - `RMS_OUT_FRAC;

  logic                   clk;
  logic                   rst_n;
  logic [`RMS_BEAT_W-1:0] in_data;
  logic                   in_valid;
  logic                   in_ready;
  logic [`RMS_BEAT_W-1:0] wt_data;
  logic                   wt_valid;
  logic                   wt_ready;
  logic [`RMS_BEAT_W-1:0] out_data;
  logic                   out_valid;
  logic                   out_last;
  logic                   out_ready;

  rms_norm_pkg::lane_beat_u in_beats [$];
  rms_norm_pkg::lane_beat_u wt_beats [$];
  logic [`RMS_BEAT_W:0]     exp_q    [$];
  logic [`RMS_BEAT_W-1:0]   exp_data;
  logic                     exp_last;
  logic                     exp_avail;
  logic [127:0]             test_name;
  int                       ready_pct;
  int                       cycle_cnt;
  int                       data_errs;
  int                       last_errs;
  int                       stall_errs;
  int                       fill_errs;
  int                       misc_errs;

  rms_norm_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .wt_data   (wt_data),
    .wt_valid  (wt_valid),
    .wt_ready  (wt_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

  rms_norm_checks u_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .wt_valid   (wt_valid),
    .wt_ready   (wt_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_ready  (out_ready),
    .exp_data   (exp_data),
    .exp_last   (exp_last),
    .exp_avail  (exp_avail),
    .test_name  (test_name),
    .data_errs  (data_errs),
    .last_errs  (last_errs),
    .stall_errs (stall_errs),
    .fill_errs  (fill_errs),
    .misc_errs  (misc_errs)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic longint lane_val(input rms_norm_pkg::lane_beat_u beat, input int l);
    return longint'($signed(beat.lane[l]));
  endfunction

  // floor(2^12 / sqrt(mt/16)) with mt = mean cut to its top six bits
  function automatic longint inv_root(input longint sum);
    longint m;
    longint mt;
    int     lead;
    real    r;
    m = sum >>> `RMS_NUM_LOG2;
    if (m == 0) begin
      return 65535;
    end
    lead = 0;
    for (int b = 0; b < `RMS_ACC_W; b++) begin
      if (m[b]) begin
        lead = b;
      end
    end
    mt = m;
    if (lead > `RMS_LUT_POW) begin
      mt = (m >>> (lead - `RMS_LUT_POW)) <<< (lead - `RMS_LUT_POW);
    end
    r = 16384.0 / $sqrt(real'(mt));
    if (r > 65535.0) begin
      return 65535;
    end
    return longint'($rtoi(r));
  endfunction

  function automatic void update_expected_head();
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) begin
      exp_data = exp_q[0][`RMS_BEAT_W-1:0];
      exp_last = exp_q[0][`RMS_BEAT_W];
    end
  endfunction

  function automatic void add_beat(input rms_norm_pkg::lane_beat_u d,
                                   input rms_norm_pkg::lane_beat_u w);
    in_beats.push_back(d);
    wt_beats.push_back(w);
  endfunction

  // Predicts the output beats of the last frame added
  task automatic model_frame();
    int                       base;
    longint                   sum;
    longint                   isq;
    longint                   p;
    rms_norm_pkg::lane_beat_u o;
    base = in_beats.size() - `RMS_BEATS;
    sum  = 0;
    for (int bt = 0; bt < `RMS_BEATS; bt++) begin
      for (int l = 0; l < `RMS_LANES; l++) begin
        sum += lane_val(in_beats[base + bt], l) * lane_val(in_beats[base + bt], l);
      end
    end
    isq = inv_root(sum);
    for (int bt = 0; bt < `RMS_BEATS; bt++) begin
      for (int l = 0; l < `RMS_LANES; l++) begin
        p = lane_val(in_beats[base + bt], l) * isq * lane_val(wt_beats[base + bt], l);
        p = p >>> OUT_SHIFT;
        if (p > 127) begin
          p = 127;
        end else if (p < -128) begin
          p = -128;
        end
        o.lane[l] = p[7:0];
      end
      exp_q.push_back({bt == `RMS_BEATS - 1, o.raw});
    end
    update_expected_head();
  endtask

  task automatic add_ramp_frame();
    rms_norm_pkg::lane_beat_u d;
    rms_norm_pkg::lane_beat_u w;
    for (int bt = 0; bt < `RMS_BEATS; bt++) begin
      for (int l = 0; l < `RMS_LANES; l++) begin
        d.lane[l] = 8'((bt * `RMS_LANES + l) * 7 - 110);
        // 1.0 in the weight format
        w.lane[l] = 8'd4;
      end
      add_beat(d, w);
    end
    model_frame();
  endtask

  task automatic add_random_frame(input bit big_weights);
    rms_norm_pkg::lane_beat_u d;
    rms_norm_pkg::lane_beat_u w;
    for (int bt = 0; bt < `RMS_BEATS; bt++) begin
      d.raw = $urandom;
      w.raw = $urandom;
      if (big_weights) begin
        for (int l = 0; l < `RMS_LANES; l++) begin
          w.lane[l] = l[0] ? 8'h80 : 8'h7f;
        end
      end
      add_beat(d, w);
    end
    model_frame();
  endtask

  task automatic add_sparse_frame(input bit all_zero);
    rms_norm_pkg::lane_beat_u d;
    rms_norm_pkg::lane_beat_u w;
    for (int bt = 0; bt < `RMS_BEATS; bt++) begin
      d.raw = '0;
      w.raw = all_zero ? $urandom : 32'h04040404;
      if (!all_zero && bt == 3) begin
        // -18.75
        d.lane[2] = 8'hb5;
      end
      add_beat(d, w);
    end
    model_frame();
  endtask

  task automatic send_inputs(input int gap_pct);
    int idx;
    idx = 0;
    while (idx < in_beats.size()) begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        idx++;
      end
      if (!in_valid || in_ready) begin
        if (idx < in_beats.size() && $urandom_range(99) >= gap_pct) begin
          in_valid <= 1'b1;
          in_data  <= in_beats[idx].raw;
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic send_weights(input int gap_pct, input int start_delay);
    int idx;
    idx = 0;
    repeat (start_delay) @(posedge clk);
    while (idx < wt_beats.size()) begin
      @(posedge clk);
      if (wt_valid && wt_ready) begin
        idx++;
      end
      if (!wt_valid || wt_ready) begin
        if (idx < wt_beats.size() && $urandom_range(99) >= gap_pct) begin
          wt_valid <= 1'b1;
          wt_data  <= wt_beats[idx].raw;
        end else begin
          wt_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic run_frames(input int in_gap, input int wt_gap, input int wt_delay);
    fork
      send_inputs(in_gap);
      send_weights(wt_gap, wt_delay);
    join
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    in_beats.delete();
    wt_beats.delete();
  endtask

  function automatic int total_errors();
    return data_errs + last_errs + stall_errs + fill_errs + misc_errs;
  endfunction

  task automatic report_counts();
    $display("Errors: data %0d, last %0d, stall %0d, fill %0d, other %0d, total %0d",
             data_errs, last_errs, stall_errs, fill_errs, misc_errs, total_errors());
  endtask

  // Retire the expected head on every output handshake
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      update_expected_head();
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      out_ready <= ($urandom_range(99) < ready_pct);
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    report_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(31));
    rst_n     = 1'b0;
    in_data   = '0;
    in_valid  = 1'b0;
    wt_data   = '0;
    wt_valid  = 1'b0;
    out_ready = 1'b0;
    ready_pct = 100;
    exp_avail = 1'b0;
    exp_data  = '0;
    exp_last  = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    test_name = "mixed_sign";
    add_ramp_frame();
    run_frames(0, 0, 0);

    test_name = "saturate";
    add_random_frame(1'b1);
    run_frames(0, 0, 0);

    // Zero mean first, then the accumulator must restart cleanly
    test_name = "zero_then_one";
    add_sparse_frame(1'b1);
    add_sparse_frame(1'b0);
    run_frames(0, 0, 0);

    test_name = "random_stall";
    ready_pct = 60;
    repeat (3) add_random_frame(1'b0);
    run_frames(30, 30, 0);
    ready_pct = 100;

    // Late weights let the buffer fill up to two frames
    test_name = "back_to_back";
    repeat (5) add_random_frame(1'b0);
    run_frames(0, 0, 40);

    repeat (4) @(posedge clk);
    report_counts();
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
